// ==== vlog.f ====
+incdir+logic
logic/ctrlport_pkg.sv
logic/ctrlport_if.sv
logic/pl_cpld_regs.sv
logic/ctrlport_bus_guard.sv
logic/pl_cpld_top.sv
test/pl_cpld_tb.sv

// ==== test/pl_cpld_tb.sv ====
// testbench for the pl cpld register subsystem
// drives the plain control port of pl_cpld_top and checks acks, status,
// read data and the led/cable outputs against a shadow model of the map

`timescale 1ns/10ps
`default_nettype none

`include "pl_cpld_config.svh"

module pl_cpld_tb
  import ctrlport_pkg::*;
();

  localparam int             CLK_PERIOD       = 4;
  localparam int             RESET_CYCLES     = 10;
  localparam int             TIMEOUT          = `CTRLPORT_TIMEOUT_CYCLES;
  localparam int             NUM_TRANSACTIONS = 40;
  localparam ctrlport_addr_t BASE             = `PL_CPLD_BASE_ADDR;

  logic             ctrlport_clk;
  logic             ctrlport_rst;
  logic             s_ctrlport_req_wr;
  logic             s_ctrlport_req_rd;
  ctrlport_addr_t   s_ctrlport_req_addr;
  ctrlport_data_t   s_ctrlport_req_data;
  logic             s_ctrlport_resp_ack;
  ctrlport_status_t s_ctrlport_resp_status;
  ctrlport_data_t   s_ctrlport_resp_data;
  logic [3:0]       qsfp0_led_active;
  logic [3:0]       qsfp0_led_link;
  logic [3:0]       qsfp1_led_active;
  logic [3:0]       qsfp1_led_link;
  cable_reg_t       ipass_cable_present;

  int errors = 0;
  int seed   = 92101;

  // shadow copies of the writable registers
  ctrlport_data_t scratch_model;
  led_reg_t       led_model;
  cable_reg_t     cable_model;
  ctrlport_data_t rdata;

  pl_cpld_top u_dut (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (s_ctrlport_req_wr),
    .s_ctrlport_req_rd      (s_ctrlport_req_rd),
    .s_ctrlport_req_addr    (s_ctrlport_req_addr),
    .s_ctrlport_req_data    (s_ctrlport_req_data),
    .s_ctrlport_resp_ack    (s_ctrlport_resp_ack),
    .s_ctrlport_resp_status (s_ctrlport_resp_status),
    .s_ctrlport_resp_data   (s_ctrlport_resp_data),
    .qsfp0_led_active       (qsfp0_led_active),
    .qsfp0_led_link         (qsfp0_led_link),
    .qsfp1_led_active       (qsfp1_led_active),
    .qsfp1_led_link         (qsfp1_led_link),
    .ipass_cable_present    (ipass_cable_present)
  );

  // ------------------------------
  // clock and watchdog
  // ------------------------------
  initial begin
    ctrlport_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ctrlport_clk = ~ctrlport_clk;
  end

  // worst case every access runs into the guard timeout
  initial begin
    #((NUM_TRANSACTIONS * (TIMEOUT + 4) + RESET_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------
  // protocol assertions
  // ------------------------------
  ack_single_pulse: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
    s_ctrlport_resp_ack |=> !s_ctrlport_resp_ack
  ) else begin
    errors++;
    $display("ack stayed high for more than one cycle");
  end

  // board outputs only move in the cycle of a write ack
  outputs_move_with_ack: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
    !$stable({qsfp0_led_active, qsfp0_led_link, qsfp1_led_active, qsfp1_led_link,
              ipass_cable_present}) |-> s_ctrlport_resp_ack
  ) else begin
    errors++;
    $display("led or cable outputs changed without an ack");
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic ctrlport_status_t status_for(input ctrlport_addr_t addr, input logic wr);
    ctrlport_addr_t offset;
    offset = addr - BASE;
    if (addr < BASE || offset >= `PL_CPLD_NUM_ADDRESSES) return `CTRL_STS_TSERR;
    case (offset)
      `SCRATCH_REGISTER, `LED_REGISTER, `CABLE_PRESENT_REG: return `CTRL_STS_OKAY;
      // identity words are read only
      `SIGNATURE_REGISTER, `REVISION_REGISTER, `OLDEST_COMPATIBLE_REVISION_REGISTER,
      `GIT_HASH_REGISTER: return wr ? `CTRL_STS_CMDERR : `CTRL_STS_OKAY;
      default: return `CTRL_STS_CMDERR;
    endcase
  endfunction

  function automatic ctrlport_data_t model_read_data(input ctrlport_addr_t addr);
    ctrlport_data_t word;
    word = '0;
    case (addr - BASE)
      `SIGNATURE_REGISTER:                  word = `PL_CPLD_SIGNATURE;
      `REVISION_REGISTER:                   word = `CPLD_REVISION;
      `OLDEST_COMPATIBLE_REVISION_REGISTER: word = `OLDEST_CPLD_REVISION;
      `GIT_HASH_REGISTER:                   word = `GIT_HASH_DEFAULT;
      `SCRATCH_REGISTER:                    word = scratch_model;
      `LED_REGISTER:                        word[15:0] = led_model;
      `CABLE_PRESENT_REG: begin
        word[`IPASS0_CABLE_PRESENT] = cable_model[0];
        word[`IPASS1_CABLE_PRESENT] = cable_model[1];
      end
      default: ;
    endcase
    return word;
  endfunction

  task automatic update_model(input ctrlport_addr_t addr, input ctrlport_data_t wdata);
    case (addr - BASE)
      `SCRATCH_REGISTER:  scratch_model = wdata;
      `LED_REGISTER:      led_model = wdata[15:0];
      `CABLE_PRESENT_REG: cable_model = {wdata[`IPASS1_CABLE_PRESENT],
                                         wdata[`IPASS0_CABLE_PRESENT]};
      default: ;
    endcase
  endtask

  // ------------------------------
  // checks
  // ------------------------------
  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic verify_outputs(input string name);
    expect_equal({name, " qsfp0 link"},
                 led_model[`QSFP0_LED_LINK +: `QSFP_LED_FIELD_SIZE], qsfp0_led_link);
    expect_equal({name, " qsfp0 active"},
                 led_model[`QSFP0_LED_ACTIVE +: `QSFP_LED_FIELD_SIZE], qsfp0_led_active);
    expect_equal({name, " qsfp1 link"},
                 led_model[`QSFP1_LED_LINK +: `QSFP_LED_FIELD_SIZE], qsfp1_led_link);
    expect_equal({name, " qsfp1 active"},
                 led_model[`QSFP1_LED_ACTIVE +: `QSFP_LED_FIELD_SIZE], qsfp1_led_active);
    expect_equal({name, " cable present"}, cable_model, ipass_cable_present);
  endtask

  // ------------------------------
  // bus access
  // ------------------------------
  // one-cycle strobe, then count falling edges until the ack shows up
  task automatic access(input string name, input logic wr, input ctrlport_addr_t addr,
                        input ctrlport_data_t wdata);
    ctrlport_status_t exp_sts;
    int               exp_cycles;
    int               cycles;
    logic             got_ack;
    exp_sts    = status_for(addr, wr);
    exp_cycles = (exp_sts == `CTRL_STS_TSERR) ? TIMEOUT : 1;
    cycles     = 0;
    got_ack    = 1'b0;
    @(negedge ctrlport_clk);
    s_ctrlport_req_wr   = wr;
    s_ctrlport_req_rd   = !wr;
    s_ctrlport_req_addr = addr;
    s_ctrlport_req_data = wdata;
    while (!got_ack && cycles < TIMEOUT + 4) begin
      @(negedge ctrlport_clk);
      cycles++;
      got_ack           = s_ctrlport_resp_ack;
      s_ctrlport_req_wr = 1'b0;
      s_ctrlport_req_rd = 1'b0;
    end
    assert (got_ack) else begin
      errors++;
      $display("%s: no ack within %0d cycles of the request", name, TIMEOUT + 4);
    end
    rdata = s_ctrlport_resp_data;
    if (got_ack) begin
      expect_equal({name, " ack latency"}, exp_cycles, cycles);
      expect_equal({name, " status"}, exp_sts, s_ctrlport_resp_status);
      if (wr && exp_sts == `CTRL_STS_OKAY) update_model(addr, wdata);
      if (exp_sts == `CTRL_STS_TSERR) expect_equal({name, " timeout data"}, 0, rdata);
      // write already visible on the outputs in the ack cycle
      verify_outputs(name);
    end
  endtask

  task automatic read_reg(input string name, input ctrlport_addr_t addr);
    access(name, 1'b0, addr, '0);
    if (status_for(addr, 1'b0) == `CTRL_STS_OKAY)
      expect_equal({name, " data"}, model_read_data(addr), rdata);
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    ctrlport_rst        = 1'b1;
    s_ctrlport_req_wr   = 1'b0;
    s_ctrlport_req_rd   = 1'b0;
    s_ctrlport_req_addr = '0;
    s_ctrlport_req_data = '0;
    scratch_model       = '0;
    led_model           = '0;
    cable_model         = '0;
    rdata               = '0;
    repeat (RESET_CYCLES) @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;
    @(negedge ctrlport_clk);
    expect_equal("reset ack", 0, s_ctrlport_resp_ack);
    verify_outputs("reset");

    // identity words
    read_reg("signature", BASE + `SIGNATURE_REGISTER);
    read_reg("revision", BASE + `REVISION_REGISTER);
    read_reg("oldest revision", BASE + `OLDEST_COMPATIBLE_REVISION_REGISTER);
    read_reg("git hash", BASE + `GIT_HASH_REGISTER);

    repeat (4) begin
      access("scratch write", 1'b1, BASE + `SCRATCH_REGISTER, $random(seed));
      read_reg("scratch read", BASE + `SCRATCH_REGISTER);
    end
    // full 32-bit writes, only the low half kept
    repeat (4) begin
      access("led write", 1'b1, BASE + `LED_REGISTER, $random(seed));
      read_reg("led read", BASE + `LED_REGISTER);
    end
    repeat (3) begin
      access("cable write", 1'b1, BASE + `CABLE_PRESENT_REG, $random(seed));
      read_reg("cable read", BASE + `CABLE_PRESENT_REG);
    end

    // holes in the map, nothing may change
    access("hole 0x14 write", 1'b1, BASE + 20'h14, $random(seed));
    read_reg("hole 0x14 read", BASE + 20'h14);
    access("hole 0x3c write", 1'b1, BASE + 20'h3C, $random(seed));
    read_reg("hole 0x3c read", BASE + 20'h3C);
    read_reg("scratch after holes", BASE + `SCRATCH_REGISTER);
    read_reg("led after holes", BASE + `LED_REGISTER);
    read_reg("cable after holes", BASE + `CABLE_PRESENT_REG);

    // outside the window, guard answers with a timeout
    read_reg("below window", BASE - 20'h4);
    read_reg("above window", BASE + `PL_CPLD_NUM_ADDRESSES);
    access("far write", 1'b1, BASE + 20'h100, $random(seed));

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/pl_cpld_top.sv ====
// pl cpld register subsystem with a plain control-port slave
// guard answers unmapped addresses, register block drives leds and cable bits

`timescale 1ns/10ps
`default_nettype none

`include "pl_cpld_config.svh"

module pl_cpld_top
  import ctrlport_pkg::*;
(
  input  wire              ctrlport_clk,
  input  wire              ctrlport_rst,

  // control port from software
  input  wire              s_ctrlport_req_wr,
  input  wire              s_ctrlport_req_rd,
  input  ctrlport_addr_t   s_ctrlport_req_addr,
  input  ctrlport_data_t   s_ctrlport_req_data,
  output logic             s_ctrlport_resp_ack,
  output ctrlport_status_t s_ctrlport_resp_status,
  output ctrlport_data_t   s_ctrlport_resp_data,

  // board outputs
  output logic [3:0]       qsfp0_led_active,
  output logic [3:0]       qsfp0_led_link,
  output logic [3:0]       qsfp1_led_active,
  output logic [3:0]       qsfp1_led_link,
  output cable_reg_t       ipass_cable_present
);

  // guard to register block
  ctrlport_if regs_ctrlport ();

  ctrlport_bus_guard u_guard (
    .ctrlport_clk           (ctrlport_clk),
    .ctrlport_rst           (ctrlport_rst),
    .s_ctrlport_req_wr      (s_ctrlport_req_wr),
    .s_ctrlport_req_rd      (s_ctrlport_req_rd),
    .s_ctrlport_req_addr    (s_ctrlport_req_addr),
    .s_ctrlport_req_data    (s_ctrlport_req_data),
    .s_ctrlport_resp_ack    (s_ctrlport_resp_ack),
    .s_ctrlport_resp_status (s_ctrlport_resp_status),
    .s_ctrlport_resp_data   (s_ctrlport_resp_data),
    .m_ctrlport             (regs_ctrlport.master)
  );

  pl_cpld_regs #(
    .BASE_ADDRESS (`PL_CPLD_BASE_ADDR)
  ) u_regs (
    .ctrlport_clk        (ctrlport_clk),
    .ctrlport_rst        (ctrlport_rst),
    .s_ctrlport          (regs_ctrlport.slave),
    .qsfp0_led_active    (qsfp0_led_active),
    .qsfp0_led_link      (qsfp0_led_link),
    .qsfp1_led_active    (qsfp1_led_active),
    .qsfp1_led_link      (qsfp1_led_link),
    .ipass_cable_present (ipass_cable_present)
  );

endmodule

`default_nettype wire

// ==== logic/ctrlport_bus_guard.sv ====
// control-port guard in front of a single slave
// forwards requests, tracks the one outstanding access and answers it
// with a timeout error when the slave stays silent

`timescale 1ns/10ps
`default_nettype none

`include "pl_cpld_config.svh"

module ctrlport_bus_guard
  import ctrlport_pkg::*;
(
  input  wire              ctrlport_clk,
  input  wire              ctrlport_rst,

  // upstream request
  input  wire              s_ctrlport_req_wr,
  input  wire              s_ctrlport_req_rd,
  input  ctrlport_addr_t   s_ctrlport_req_addr,
  input  ctrlport_data_t   s_ctrlport_req_data,
  // upstream response
  output logic             s_ctrlport_resp_ack,
  output ctrlport_status_t s_ctrlport_resp_status,
  output ctrlport_data_t   s_ctrlport_resp_data,

  // downstream slave
  ctrlport_if.master       m_ctrlport
);

  localparam int TIMEOUT = `CTRLPORT_TIMEOUT_CYCLES;
  localparam int CNT_W   = $clog2(TIMEOUT + 1);

  guard_state_t     state;
  // cycles since the forwarded request, 1 in the cycle after it
  logic [CNT_W-1:0] wait_cnt;

  logic             req_any;
  logic             busy;
  logic             fwd_req;
  logic             timeout_ack;

  // ------------------------------
  // request path
  // ------------------------------
  assign req_any = s_ctrlport_req_wr | s_ctrlport_req_rd;

  // outstanding access not finished in this cycle
  assign busy    = (state == wait_ack) && !s_ctrlport_resp_ack;
  assign fwd_req = req_any && !busy;

  assign m_ctrlport.req_wr   = s_ctrlport_req_wr && !busy;
  assign m_ctrlport.req_rd   = s_ctrlport_req_rd && !busy;
  assign m_ctrlport.req_addr = s_ctrlport_req_addr;
  assign m_ctrlport.req_data = s_ctrlport_req_data;

  // ------------------------------
  // response path
  // ------------------------------
  // own ack in the cycle TIMEOUT after the request, slave wins a tie
  assign timeout_ack = (state == wait_ack) &&
                       (wait_cnt == CNT_W'(TIMEOUT)) &&
                       !m_ctrlport.resp_ack;

  assign s_ctrlport_resp_ack    = m_ctrlport.resp_ack | timeout_ack;
  assign s_ctrlport_resp_status = timeout_ack ? `CTRL_STS_TSERR : m_ctrlport.resp_status;
  assign s_ctrlport_resp_data   = timeout_ack ? '0 : m_ctrlport.resp_data;

  // ------------------------------
  // fsm and counter
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state    <= idle;
      wait_cnt <= '0;
    end else if (fwd_req) begin
      // new access, also back to back with the previous ack
      state    <= wait_ack;
      wait_cnt <= CNT_W'(1);
    end else if (s_ctrlport_resp_ack) begin
      state    <= idle;
      wait_cnt <= '0;
    end else if (state == wait_ack) begin
      wait_cnt <= wait_cnt + CNT_W'(1);
    end
  end

  // upstream kept to one outstanding request
  a_no_req_while_busy: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
    busy |-> !req_any
  ) else $error("control port request issued before the previous ack");

  // slave must only answer something that was forwarded
  a_no_ack_while_idle: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
    (state == idle) |-> !m_ctrlport.resp_ack
  ) else $error("slave ack without an outstanding request");

endmodule

`default_nettype wire

// ==== logic/pl_cpld_regs.sv ====
// identity, scratch, qsfp led and ipass cable-present registers
// answers control-port requests inside its 64-byte window one cycle later
// addresses outside the window are ignored, no ack

`timescale 1ns/10ps
`default_nettype none

`include "pl_cpld_config.svh"

module pl_cpld_regs
  import ctrlport_pkg::*;
#(
  parameter ctrlport_addr_t BASE_ADDRESS = `PL_CPLD_BASE_ADDR
) (
  input  wire        ctrlport_clk,
  input  wire        ctrlport_rst,

  ctrlport_if.slave  s_ctrlport,

  // qsfp leds
  output logic [3:0] qsfp0_led_active,
  output logic [3:0] qsfp0_led_link,
  output logic [3:0] qsfp1_led_active,
  output logic [3:0] qsfp1_led_link,

  // ipass status
  output cable_reg_t ipass_cable_present
);

  // ------------------------------
  // address decode
  // ------------------------------
  logic             req_valid;
  logic             addr_in_range;
  ctrlport_addr_t   addr_offset;

  // register state
  ctrlport_data_t   scratch_reg;
  led_reg_t         led_reg;
  cable_reg_t       cable_reg;

  // decoded response for the current request
  ctrlport_status_t wr_status;
  ctrlport_status_t rd_status;
  ctrlport_data_t   rd_data;

  assign req_valid = s_ctrlport.req_wr | s_ctrlport.req_rd;

  // offset wraps below the base, so the lower bound is checked on its own
  assign addr_offset   = s_ctrlport.req_addr - BASE_ADDRESS;
  assign addr_in_range = (s_ctrlport.req_addr >= BASE_ADDRESS) &&
                         (addr_offset < ctrlport_addr_t'(`PL_CPLD_NUM_ADDRESSES));

  // ------------------------------
  // outputs
  // ------------------------------
  assign qsfp0_led_link   = led_reg[`QSFP0_LED_LINK +: `QSFP_LED_FIELD_SIZE];
  assign qsfp0_led_active = led_reg[`QSFP0_LED_ACTIVE +: `QSFP_LED_FIELD_SIZE];
  assign qsfp1_led_link   = led_reg[`QSFP1_LED_LINK +: `QSFP_LED_FIELD_SIZE];
  assign qsfp1_led_active = led_reg[`QSFP1_LED_ACTIVE +: `QSFP_LED_FIELD_SIZE];

  assign ipass_cable_present = cable_reg;

  // ------------------------------
  // write decode
  // ------------------------------
  // only the three writable registers accept writes
  always_comb begin
    wr_status = `CTRL_STS_CMDERR;
    case (addr_offset)
      `SCRATCH_REGISTER,
      `LED_REGISTER,
      `CABLE_PRESENT_REG: wr_status = `CTRL_STS_OKAY;
      default: ;
    endcase
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb begin
    rd_status = `CTRL_STS_OKAY;
    rd_data   = '0;
    case (addr_offset)
      `SIGNATURE_REGISTER:                  rd_data = `PL_CPLD_SIGNATURE;
      `REVISION_REGISTER:                   rd_data = `CPLD_REVISION;
      `OLDEST_COMPATIBLE_REVISION_REGISTER: rd_data = `OLDEST_CPLD_REVISION;
      `SCRATCH_REGISTER:                    rd_data = scratch_reg;
      `GIT_HASH_REGISTER:                   rd_data = `GIT_HASH_DEFAULT;
      // zero-extended to the bus width
      `LED_REGISTER:                        rd_data = ctrlport_data_t'(led_reg);
      `CABLE_PRESENT_REG: begin
        rd_data[`IPASS0_CABLE_PRESENT] = cable_reg[0];
        rd_data[`IPASS1_CABLE_PRESENT] = cable_reg[1];
      end
      // hole in the map
      default: rd_status = `CTRL_STS_CMDERR;
    endcase
  end

  // ------------------------------
  // register updates
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      scratch_reg <= '0;
      led_reg     <= '0;
      cable_reg   <= '0;
    end else if (s_ctrlport.req_wr && addr_in_range) begin
      case (addr_offset)
        `SCRATCH_REGISTER: scratch_reg <= s_ctrlport.req_data;
        // upper half of the word dropped
        `LED_REGISTER:     led_reg <= s_ctrlport.req_data[15:0];
        `CABLE_PRESENT_REG: begin
          cable_reg[0] <= s_ctrlport.req_data[`IPASS0_CABLE_PRESENT];
          cable_reg[1] <= s_ctrlport.req_data[`IPASS1_CABLE_PRESENT];
        end
        // read-only or undefined, nothing changes
        default: ;
      endcase
    end
  end

  // ------------------------------
  // response
  // ------------------------------
  // ack only inside the window
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      s_ctrlport.resp_ack <= 1'b0;
    end else begin
      s_ctrlport.resp_ack <= req_valid && addr_in_range;
    end
  end

  // status and data only matter with the ack
  always_ff @(posedge ctrlport_clk) begin
    if (s_ctrlport.req_wr) begin
      s_ctrlport.resp_status <= wr_status;
      s_ctrlport.resp_data   <= '0;
    end else if (s_ctrlport.req_rd) begin
      s_ctrlport.resp_status <= rd_status;
      s_ctrlport.resp_data   <= rd_data;
    end
  end

  // master side must never strobe both
  a_single_strobe: assert property (
    @(posedge ctrlport_clk) disable iff (ctrlport_rst)
    !(s_ctrlport.req_wr && s_ctrlport.req_rd)
  ) else $error("control port write and read strobes in the same cycle");

endmodule

`default_nettype wire

// ==== logic/ctrlport_if.sv ====
// control-port request/response bundle between blocks inside the design
// master drives the request, slave drives the response
// requests are one-cycle strobes, one outstanding at a time

`timescale 1ns/10ps
`default_nettype none

interface ctrlport_if
  import ctrlport_pkg::*;
();

  // ------------------------------
  // request, master to slave
  // ------------------------------
  logic             req_wr;
  logic             req_rd;
  ctrlport_addr_t   req_addr;
  ctrlport_data_t   req_data;

  // response, slave to master
  logic             resp_ack;
  ctrlport_status_t resp_status;
  ctrlport_data_t   resp_data;

  modport master (
    output req_wr, req_rd, req_addr, req_data,
    input  resp_ack, resp_status, resp_data
  );

  modport slave (
    input  req_wr, req_rd, req_addr, req_data,
    output resp_ack, resp_status, resp_data
  );

endinterface

`default_nettype wire

// ==== logic/ctrlport_pkg.sv ====
// vector types for the control port and the pl cpld registers
// import with ctrlport_pkg::* in the module header where needed

`default_nettype none

package ctrlport_pkg;

  // ------------------------------
  // control port fields
  // ------------------------------
  typedef logic [19:0] ctrlport_addr_t;
  typedef logic [31:0] ctrlport_data_t;
  typedef logic [1:0]  ctrlport_status_t;

  // register contents
  // four 4-bit led groups
  typedef logic [15:0] led_reg_t;
  // one bit per ipass connector
  typedef logic [1:0]  cable_reg_t;

  // bus guard fsm
  typedef enum logic {
    idle,
    wait_ack
  } guard_state_t;

endpackage

`default_nettype wire

// ==== logic/pl_cpld_config.svh ====
// register map and fixed values for the pl cpld control-port registers
// shared by the RTL and the testbench so both decode the same map
// include after adding logic/ to the include path

`ifndef PL_CPLD_CONFIG_SVH
`define PL_CPLD_CONFIG_SVH

// ------------------------------
// response status codes
// ------------------------------
`define CTRL_STS_OKAY    2'd0
`define CTRL_STS_CMDERR  2'd1
`define CTRL_STS_TSERR   2'd2
`define CTRL_STS_WARNING 2'd3

// register window
`define PL_CPLD_BASE_ADDR     20'h00200
`define PL_CPLD_NUM_ADDRESSES 64

// byte offsets inside the window
`define SIGNATURE_REGISTER                  20'h00
`define REVISION_REGISTER                   20'h04
`define OLDEST_COMPATIBLE_REVISION_REGISTER 20'h08
`define SCRATCH_REGISTER                    20'h0C
`define GIT_HASH_REGISTER                   20'h10
`define LED_REGISTER                        20'h20
`define CABLE_PRESENT_REG                   20'h30

// identity, revisions are YYMMDDHH
`define PL_CPLD_SIGNATURE    32'h0A522D27
`define CPLD_REVISION        32'h21012015
`define OLDEST_CPLD_REVISION 32'h20122114
`define GIT_HASH_DEFAULT     32'hDEADBEEF

// led register fields, lsb of each 4-bit group
`define QSFP_LED_FIELD_SIZE 4
`define QSFP0_LED_LINK      0
`define QSFP0_LED_ACTIVE    4
`define QSFP1_LED_LINK      8
`define QSFP1_LED_ACTIVE    12

// cable-present bits
`define IPASS0_CABLE_PRESENT 0
`define IPASS1_CABLE_PRESENT 1

// cycles the guard waits for a slave ack
`define CTRLPORT_TIMEOUT_CYCLES 16

`endif
